/* bench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for 8 cycles, released just after an edge
  initial begin
    resetn = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    resetn = 1'b0;
  end

endmodule

/* bench/tb_svm_top.sv */
// Space vector modulator testbench
`timescale 1ns/100ps

module tb_svm_top import svm_pkg::*;;

  localparam real pi_val = 3.141592653589793;
  // Longest wait for any cycle target
  localparam int edge_limit = 2 * pwm_period + 16;

  logic       clk;
  logic       resetn;
  logic       enable;
  logic       step;
  logic       dir;
  current_t   current;
  logic [1:0] vref_pwm;
  phase_ct_t  phase_ct;
  duty_t      duty_a;
  duty_t      duty_b;

  // Cycle count from reset release
  // Every multiple of 4096 is a period start
  int unsigned edge_ct = 0;
  logic [15:0] lfsr_state;

  // Reference model state
  phase_ct_t model_phase;
  duty_t     model_duty_a;
  duty_t     model_duty_b;

  int err_ct = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err_base;

  tb_clock_gen u_clk (
    .clk    (clk),
    .resetn (resetn)
  );

  svm_top #(
    .center_aligned (1'b1)
  ) uut (
    .clk      (clk),
    .resetn   (resetn),
    .enable   (enable),
    .step     (step),
    .dir      (dir),
    .current  (current),
    .vref_pwm (vref_pwm),
    .phase_ct (phase_ct),
    .duty_a   (duty_a),
    .duty_b   (duty_b)
  );

  always @(posedge clk) begin
    if (resetn) begin
      edge_ct <= 0;
    end else begin
      edge_ct <= edge_ct + 1;
    end
  end

  // Fibonacci taps 16 14 13 11 with one shift per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    logic        fb;
    val = 0;
    for (int i = 0; i < n; i++) begin
      fb = ^(lfsr_state & 16'hb400);
      lfsr_state = {lfsr_state[14:0], fb};
      val = (val << 1) | fb;
    end
    return val;
  endfunction

  // Truncated sin(pi * i / 128) at full scale
  function automatic int sine_mag(input int idx);
    return $rtoi($sin(pi_val * idx / 128.0) * 255.0);
  endfunction

  // Model duties with the cosine a quarter wave on
  function automatic void model_commit(input current_t cur);
    int idx;
    idx = model_phase % 128;
    model_duty_a = sine_mag(idx) * int'(cur);
    model_duty_b = sine_mag((idx + 64) % 128) * int'(cur);
  endfunction

  // Inputs change and outputs are sampled 2 ns after the edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_phase(input string name, input phase_ct_t got, input phase_ct_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      err_ct++;
    end
  endtask

  task automatic check_duty(input string name, input duty_t got, input duty_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      err_ct++;
    end
  endtask

  task automatic check_pwm_width(input string name, input duty_t got, input duty_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      err_ct++;
    end
  endtask

  task automatic wait_edge(input int unsigned target);
    int n;
    n = 0;
    while (edge_ct != target && n < edge_limit) begin
      tick();
      n++;
    end
    if (edge_ct != target) begin
      $display("timeout at %0t: cycle %0d after reset was never reached", $time, target);
      err_ct++;
    end
  endtask

  // First cycle of the next period after now
  task automatic wait_period();
    wait_edge((edge_ct / pwm_period + 1) * pwm_period + 1);
  endtask

  // Counts high cycles over one period from its first output cycle
  task automatic check_period(input duty_t exp_a, input duty_t exp_b);
    duty_t hi_a;
    duty_t hi_b;
    int    first_a;
    int    last_a;
    int    first_b;
    int    last_b;
    int    gap;
    hi_a = '0;
    hi_b = '0;
    first_a = -1;
    first_b = -1;
    last_a = 0;
    last_b = 0;
    for (int i = 0; i < pwm_period; i++) begin
      if (i > 0) begin
        tick();
      end
      if (vref_pwm[0]) begin
        hi_a++;
        if (first_a < 0) begin
          first_a = i;
        end
        last_a = i;
      end
      if (vref_pwm[1]) begin
        hi_b++;
        if (first_b < 0) begin
          first_b = i;
        end
        last_b = i;
      end
    end
    check_pwm_width("vref_pwm[0] width", hi_a, exp_a);
    check_pwm_width("vref_pwm[1] width", hi_b, exp_b);
    // Midpoints compared in half cycles
    if (hi_a != 0 && hi_b != 0) begin
      gap = (first_a + last_a) - (first_b + last_b);
      if (gap > 2 || gap < -2) begin
        $display("pulse centres at %0t are %0d half cycles apart", $time, gap);
        err_ct++;
      end
    end
  endtask

  // One microstep followed by phase, duty and pulse checks
  task automatic do_step(input logic up, input current_t cur);
    int unsigned s;
    int unsigned commit_edge;
    s = edge_ct;
    step = 1'b1;
    dir = up;
    current = cur;
    tick();
    step = 1'b0;
    tick();
    model_phase = up ? model_phase + 1 : model_phase - 1;
    check_phase("phase_ct", phase_ct, model_phase);
    // Commit at the first period start once scaling is done
    commit_edge = ((s + 3 + pwm_period - 1) / pwm_period) * pwm_period;
    wait_edge(commit_edge + 1);
    model_commit(cur);
    check_duty("duty_a", duty_a, model_duty_a);
    check_duty("duty_b", duty_b, model_duty_b);
    check_period(model_duty_a, model_duty_b);
    repeat (8 + rand_bits(12)) tick();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_ct > test_err_base) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, err_ct - test_err_base);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_err_base = err_ct;
  endtask

  initial begin
    current_t cur;
    lfsr_state = 16'd20392;
    enable = 1'b1;
    step = 1'b0;
    dir = 1'b0;
    // Nonzero so the first commit shows a pulse
    cur = current_t'(rand_bits(4));
    if (cur == '0) begin
      cur = 4'd1;
    end
    current = cur;
    model_phase = '0;
    model_duty_a = '0;
    model_duty_b = '0;
    test_err_base = 0;

    // Dark first period before the angle 0 commit
    wait_edge(1);
    check_duty("duty_a", duty_a, 0);
    check_duty("duty_b", duty_b, 0);
    check_period(0, 0);
    wait_edge(pwm_period + 1);
    model_commit(cur);
    check_duty("duty_a", duty_a, model_duty_a);
    check_duty("duty_b", duty_b, model_duty_b);
    check_period(model_duty_a, model_duty_b);
    end_test("reset and initial commit");

    // Wrap below 0 and back over 255
    do_step(1'b0, cur);
    do_step(1'b1, cur);
    end_test("phase wrap both ways");

    for (int i = 0; i < 8; i++) begin
      do_step(rand_bits(1), current_t'(rand_bits(4)));
    end
    end_test("random steps");

    // New current alone commits nothing
    cur = current ^ current_t'(1 + rand_bits(3));
    current = cur;
    wait_period();
    check_duty("duty_a", duty_a, model_duty_a);
    check_duty("duty_b", duty_b, model_duty_b);
    do_step(rand_bits(1), cur);
    end_test("current change");

    // Step ignored and outputs dark while disabled
    enable = 1'b0;
    dir = rand_bits(1);
    tick();
    step = 1'b1;
    tick();
    step = 1'b0;
    tick();
    check_phase("phase_ct", phase_ct, model_phase);
    wait_period();
    check_period(0, 0);
    check_phase("phase_ct", phase_ct, model_phase);
    check_duty("duty_a", duty_a, model_duty_a);
    check_duty("duty_b", duty_b, model_duty_b);
    enable = 1'b1;
    repeat (4) tick();
    // Ignored step must not be served once enabled again
    check_phase("phase_ct", phase_ct, model_phase);
    end_test("enable low");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_ct);
    if (err_ct == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* common/svm_pkg.sv */
// Space vector modulator shared definitions

package svm_pkg;

  // Current amplitude width
  localparam int current_bits = 4;
  // Table magnitude width
  localparam int microstep_bits = 8;
  // Microsteps per quarter wave
  localparam int microsteps = 64;
  // One electrical turn is 256 counts
  localparam int phase_ct_bits = 8;
  // Half wave held in the table
  localparam int table_depth = 2 * microsteps;
  // Magnitude times current
  localparam int duty_bits = microstep_bits + current_bits;
  // PWM period in clk cycles
  localparam int pwm_period = 4096;

  // Phase vector amplitude
  typedef logic [current_bits-1:0] current_t;
  // Electrical angle
  typedef logic [phase_ct_bits-1:0] phase_ct_t;
  // Half-wave index, low bits of the angle
  typedef logic [phase_ct_bits-2:0] table_idx_t;
  // Sine magnitude
  typedef logic [microstep_bits-1:0] mag_t;
  // On-time in cycles
  typedef logic [duty_bits-1:0] duty_t;
  // Turn-on delay, at most half a duty
  typedef logic [duty_bits-2:0] delay_t;
  // PWM period counter
  typedef logic [duty_bits-1:0] pwm_ct_t;

  // Sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_fetch,
    seq_scale,
    seq_commit
  } seq_state_t;

endpackage

/* compile.f */
common/svm_pkg.sv
pwm/pwm_timebase.sv
pwm/pwm_channel.sv
hdl/sine_lookup.sv
hdl/duty_scaler.sv
hdl/step_sequencer.sv
hdl/svm_top.sv
bench/tb_clock_gen.sv
bench/tb_svm_top.sv

/* hdl/duty_scaler.sv */
// Duty scaling and centring
`timescale 1ns/100ps

module duty_scaler import svm_pkg::*; #(
  parameter bit center_aligned = 1'b1
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     scale_en,
  input  current_t current,
  input  mag_t     mag_a,
  input  mag_t     mag_b,
  output duty_t    duty_a_next,
  output duty_t    duty_b_next,
  output delay_t   delay_a_next,
  output delay_t   delay_b_next
);

  // Magnitude times current, 255 x 15 at most
  duty_t prod_a;
  duty_t prod_b;
  // Gap between the two on-times
  duty_t diff;
  delay_t dly_a;
  delay_t dly_b;

  assign prod_a = mag_a * current;
  assign prod_b = mag_b * current;

  assign diff = (prod_a > prod_b) ? prod_a - prod_b : prod_b - prod_a;

  // Centre aligned
  // A: ___|-------|____
  // B: ______|-|_______
  // Smaller pulse starts half the gap late, rounded down
  always_comb begin
    dly_a = '0;
    dly_b = '0;
    if (center_aligned) begin
      if (prod_a < prod_b) begin
        dly_a = diff[duty_bits-1:1];
      end else if (prod_b < prod_a) begin
        dly_b = diff[duty_bits-1:1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      duty_a_next  <= '0;
      duty_b_next  <= '0;
      delay_a_next <= '0;
      delay_b_next <= '0;
    end else if (scale_en) begin
      // Current sampled here only
      duty_a_next  <= prod_a;
      duty_b_next  <= prod_b;
      delay_a_next <= dly_a;
      delay_b_next <= dly_b;
    end
  end

endmodule

/* hdl/sine_lookup.sv */
// Half-wave sine table
`timescale 1ns/100ps

module sine_lookup import svm_pkg::*; (
  input  logic       clk,
  input  logic       lookup_en,
  input  table_idx_t table_idx,
  output mag_t       mag_a,
  output mag_t       mag_b
);

  localparam real pi = 3.14159265358979;
  // Full scale magnitude
  localparam real mag_max = 2.0 ** microstep_bits - 1.0;

  // Half wave keeps a true zero crossing
  mag_t sine_rom [0:table_depth-1];

  // Cosine sits a quarter wave further on
  table_idx_t cos_idx;

  // ROM contents, truncated toward zero
  initial begin
    for (int i = 0; i < table_depth; i++) begin
      sine_rom[i] = mag_t'($rtoi($sin(pi * i / table_depth) * mag_max));
    end
  end

  // Wraps inside the 128 entries
  assign cos_idx = table_idx + table_idx_t'(microsteps);

  // Registered reads, no reset so it maps to block RAM
  always_ff @(posedge clk) begin
    if (lookup_en) begin
      mag_a <= sine_rom[table_idx];
      mag_b <= sine_rom[cos_idx];
    end
  end

endmodule

/* hdl/step_sequencer.sv */
// Step sequencer FSM
`timescale 1ns/100ps

module step_sequencer import svm_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  logic       enable,
  input  logic       step,
  input  logic       dir,
  input  logic       period_start,
  output phase_ct_t  phase_ct,
  output table_idx_t table_idx,
  output logic       lookup_en,
  output logic       scale_en,
  output logic       commit
);

  seq_state_t state;

  // One queued step and its direction
  logic pend;
  logic pend_dir;
  // Update owed after reset, no step needed
  logic init_req;

  // One microstep either way, wraps at 256
  function automatic phase_ct_t stepped(input phase_ct_t ph, input logic up);
    phase_ct_t res;
    if (up) begin
      res = ph + 1'b1;
    end else begin
      res = ph - 1'b1;
    end
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (resetn) begin
      state    <= seq_idle;
      phase_ct <= '0;
      pend     <= 1'b0;
      pend_dir <= 1'b0;
      init_req <= 1'b1;
    end else begin
      case (state)
        seq_idle: begin
          if (init_req) begin
            // Angle 0 update, a step here waits its turn
            init_req <= 1'b0;
            state    <= seq_fetch;
            if (step && enable) begin
              pend     <= 1'b1;
              pend_dir <= dir;
            end
          end else if (pend && enable) begin
            phase_ct <= stepped(phase_ct, pend_dir);
            pend     <= 1'b0;
            state    <= seq_fetch;
          end else if (step && enable && !pend) begin
            phase_ct <= stepped(phase_ct, dir);
            state    <= seq_fetch;
          end
        end
        seq_fetch: begin
          state <= seq_scale;
        end
        seq_scale: begin
          state <= seq_commit;
        end
        seq_commit: begin
          // Hold until the period boundary
          if (period_start) begin
            state <= seq_idle;
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
      // Busy, keep only the first step
      if (state != seq_idle && step && enable && !pend) begin
        pend     <= 1'b1;
        pend_dir <= dir;
      end
    end
  end

  // Cosine offset is applied in the lookup
  assign table_idx = phase_ct[phase_ct_bits-2:0];

  assign lookup_en = (state == seq_fetch);
  assign scale_en  = (state == seq_scale);
  // Same cycle as the count 0 strobe
  assign commit    = (state == seq_commit) && period_start;

endmodule

/* hdl/svm_top.sv */
// Two-phase space vector modulator
`timescale 1ns/100ps

module svm_top import svm_pkg::*; #(
  parameter bit center_aligned = 1'b1
) (
  input  logic      clk,
  input  logic      resetn,
  input  logic      enable,
  input  logic      step,
  input  logic      dir,
  input  current_t  current,
  output logic [1:0] vref_pwm,
  output phase_ct_t phase_ct,
  output duty_t     duty_a,
  output duty_t     duty_b
);

  // Sequencer strobes
  table_idx_t table_idx;
  logic       lookup_en;
  logic       scale_en;
  logic       commit;

  // Table magnitudes, sine then cosine
  mag_t mag_a;
  mag_t mag_b;

  // Scaled values waiting for the next period
  duty_t  duty_a_next;
  duty_t  duty_b_next;
  delay_t delay_a_next;
  delay_t delay_b_next;

  // Shared PWM timebase
  pwm_ct_t pwm_ct;
  logic    period_start;

  step_sequencer u_seq (
    .clk          (clk),
    .resetn       (resetn),
    .enable       (enable),
    .step         (step),
    .dir          (dir),
    .period_start (period_start),
    .phase_ct     (phase_ct),
    .table_idx    (table_idx),
    .lookup_en    (lookup_en),
    .scale_en     (scale_en),
    .commit       (commit)
  );

  sine_lookup u_lookup (
    .clk       (clk),
    .lookup_en (lookup_en),
    .table_idx (table_idx),
    .mag_a     (mag_a),
    .mag_b     (mag_b)
  );

  duty_scaler #(
    .center_aligned (center_aligned)
  ) u_scaler (
    .clk          (clk),
    .resetn       (resetn),
    .scale_en     (scale_en),
    .current      (current),
    .mag_a        (mag_a),
    .mag_b        (mag_b),
    .duty_a_next  (duty_a_next),
    .duty_b_next  (duty_b_next),
    .delay_a_next (delay_a_next),
    .delay_b_next (delay_b_next)
  );

  pwm_timebase u_timebase (
    .clk          (clk),
    .resetn       (resetn),
    .pwm_ct       (pwm_ct),
    .period_start (period_start)
  );

  // Sine channel
  pwm_channel u_chan_a (
    .clk        (clk),
    .resetn     (resetn),
    .enable     (enable),
    .commit     (commit),
    .pwm_ct     (pwm_ct),
    .duty_next  (duty_a_next),
    .delay_next (delay_a_next),
    .duty       (duty_a),
    .pwm        (vref_pwm[0])
  );

  // Cosine channel
  pwm_channel u_chan_b (
    .clk        (clk),
    .resetn     (resetn),
    .enable     (enable),
    .commit     (commit),
    .pwm_ct     (pwm_ct),
    .duty_next  (duty_b_next),
    .delay_next (delay_b_next),
    .duty       (duty_b),
    .pwm        (vref_pwm[1])
  );

endmodule

/* pwm/pwm_channel.sv */
// PWM output channel
`timescale 1ns/100ps

module pwm_channel import svm_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  input  logic    enable,
  input  logic    commit,
  input  pwm_ct_t pwm_ct,
  input  duty_t   duty_next,
  input  delay_t  delay_next,
  output duty_t   duty,
  output logic    pwm
);

  // Shadow turn-on delay
  delay_t delay;

  // Values in force for this count
  duty_t  eff_duty;
  delay_t eff_delay;
  // End of the on window, one bit wider
  logic [duty_bits:0] win_end;
  logic               in_win;

  // New values already count at count 0
  assign eff_duty  = commit ? duty_next : duty;
  assign eff_delay = commit ? delay_next : delay;

  assign win_end = {1'b0, eff_duty} + eff_delay;
  assign in_win  = (pwm_ct >= eff_delay) && (pwm_ct < win_end);

  // Shadow registers, only touched at a period start
  always_ff @(posedge clk) begin
    if (resetn) begin
      duty  <= '0;
      delay <= '0;
    end else if (commit) begin
      duty  <= duty_next;
      delay <= delay_next;
    end
  end

  // Registered output, low while disabled
  always_ff @(posedge clk) begin
    if (resetn) begin
      pwm <= 1'b0;
    end else begin
      pwm <= enable && in_win;
    end
  end

endmodule

/* pwm/pwm_timebase.sv */
// PWM period counter
`timescale 1ns/100ps

module pwm_timebase import svm_pkg::*; (
  input  logic    clk,
  input  logic    resetn,
  output pwm_ct_t pwm_ct,
  output logic    period_start
);

  // Last count of the period
  logic last_ct;

  assign last_ct = (pwm_ct == pwm_ct_t'(pwm_period - 1));

  // Free running, also while enable is low
  always_ff @(posedge clk) begin
    if (resetn) begin
      pwm_ct       <= '0;
      period_start <= 1'b0;
    end else begin
      // High in the cycle the count reads 0 again
      period_start <= last_ct;
      if (last_ct) begin
        pwm_ct <= '0;
      end else begin
        pwm_ct <= pwm_ct + 1'b1;
      end
    end
  end

endmodule
